// File: verilog/bus_pkg.sv
package bus_pkg;

	////////////////////////////////////////////////////////////
	// CPU side request and response
	////////////////////////////////////////////////////////////

	// Request as held by a CPU port
	// Same layout for main and sub
	typedef struct packed {
		// Full 8K work RAM address
		logic [12:0] addr;
		// Write data, unused on a read
		logic [7:0]  wdata;
		// High for read
		logic        rnw;
		// Bit i steers a write to latch i
		logic [1:0]  lth;
	} bus_req_t;

	// Read data returned on ack
	typedef struct packed {
		logic [7:0] rdata;
	} bus_rsp_t;

	////////////////////////////////////////////////////////////
	// RAM side command
	////////////////////////////////////////////////////////////

	// One command per access slot
	typedef struct packed {
		// Access strobe
		logic        en;
		// Write when set, read otherwise
		logic        we;
		logic [12:0] addr;
		logic [7:0]  wdata;
	} ram_cmd_t;

	// Slot owner, follows 2H
	// Main in the low half, sub in the high half
	typedef enum logic {
		owner_main = 1'b0,
		owner_sub  = 1'b1
	} slot_owner_e;

endpackage

// File: verilog/slot_timer.sv
`timescale 1ns/100ps

module slot_timer import bus_pkg::*; (
	input  logic        clk_6m,
	input  logic        arst_n,
	output slot_owner_e owner,
	output logic        acc
);

	////////////////////////////////////////////////////////////
	// 1H / 2H phase count
	////////////////////////////////////////////////////////////

	// Bit 0 plays the part of 1H
	// Bit 1 plays the part of 2H
	logic [1:0] phase;

	// Free running, four clocks per full cycle
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			phase <= 2'd0;
		end else begin
			phase <= phase + 2'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Slot decode
	////////////////////////////////////////////////////////////

	// 2H selects the source
	// Phases 0 and 1 main, 2 and 3 sub
	assign owner = phase[1] ? owner_sub : owner_main;

	// Second clock of each half
	// Gives the port one clock of setup in its slot
	assign acc = phase[0];

	// Access pulses alternate owners
	// Never back to back, so one command per slot
	a_acc_no_repeat: assert property (
		@(posedge clk_6m) disable iff (!arst_n)
		acc |=> !acc
	);

endmodule

// File: verilog/cpu_port.sv
`timescale 1ns/100ps

module cpu_port import bus_pkg::*; (
	input  logic     clk_6m,
	input  logic     arst_n,
	// CPU side, four phase
	input  logic     req,
	input  bus_req_t cmd,
	output logic     ack,
	output bus_rsp_t rsp,
	// Bus side
	output logic     pend,
	output bus_req_t held,
	input  logic     done,
	input  bus_rsp_t done_rsp
);

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		st_idle,
		st_pend,
		st_ack,
		st_rel
	} state_t;

	state_t state;

	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				// Wait for req
				st_idle: if (req) state <= st_pend;
				// Wait for the bus to serve our slot
				st_pend: if (done) state <= st_ack;
				// Hold ack until the CPU lets go
				st_ack:  if (!req) state <= st_rel;
				// One clock with ack low before a new req is taken
				st_rel:  state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Request held for the mux
	// Captured once as req is seen
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			held <= '0;
		end else if (state == st_idle && req) begin
			held <= cmd;
		end
	end

	// Read data kept on done until the next access
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			rsp <= '0;
		end else if (done) begin
			rsp <= done_rsp;
		end
	end

	assign pend = (state == st_pend);
	// Ack rises the clock after done
	assign ack  = (state == st_ack);

	// CPU keeps cmd steady for the whole transfer
	a_cmd_stable: assert property (
		@(posedge clk_6m) disable iff (!arst_n)
		(req && !ack) |=> (!req || $stable(cmd))
	);

	// Mux only answers a port it was serving
	a_done_pend: assert property (
		@(posedge clk_6m) disable iff (!arst_n)
		done |-> pend
	);

endmodule

// File: verilog/bus_mux.sv
`timescale 1ns/100ps

module bus_mux import bus_pkg::*; #(
	parameter int ADDR_W = 13
) (
	input  logic        clk_6m,
	input  logic        arst_n,
	input  slot_owner_e owner,
	input  logic        acc,
	input  logic        main_pend,
	input  bus_req_t    main_held,
	input  logic        sub_pend,
	input  bus_req_t    sub_held,
	output logic        main_done,
	output logic        sub_done,
	output bus_rsp_t    rsp,
	output ram_cmd_t    ram_cmd,
	input  logic [7:0]  ram_rdata,
	output logic [1:0]  lth_we,
	output logic [7:0]  lth_data
);

	// Low ADDR_W address bits reach the RAM
	localparam int unsigned ADDR_WORDS = 2 ** ADDR_W;
	localparam logic [12:0] ADDR_MASK  = 13'(ADDR_WORDS - 1);

	////////////////////////////////////////////////////////////
	// Source select
	////////////////////////////////////////////////////////////

	bus_req_t    sel_req;
	logic        sel_pend;
	logic        issue;
	logic        to_lth;
	logic        done_r;
	slot_owner_e served;

	// Like the 257/157 pair switched by 2H
	assign sel_req  = (owner == owner_main) ? main_held : sub_held;
	assign sel_pend = (owner == owner_main) ? main_pend : sub_pend;

	// Access only in the owner's access clock
	assign issue  = acc && sel_pend;
	// Writes with a latch select skip the RAM
	assign to_lth = !sel_req.rnw && (sel_req.lth != 2'b00);

	always_comb begin
		ram_cmd.en    = issue && !to_lth;
		ram_cmd.we    = !sel_req.rnw;
		ram_cmd.addr  = sel_req.addr & ADDR_MASK;
		ram_cmd.wdata = sel_req.wdata;
	end

	assign lth_we   = (issue && to_lth) ? sel_req.lth : 2'b00;
	assign lth_data = sel_req.wdata;

	////////////////////////////////////////////////////////////
	// Completion
	////////////////////////////////////////////////////////////

	// Remember who got the slot
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			done_r <= 1'b0;
			served <= owner_main;
		end else begin
			done_r <= issue;
			if (issue) served <= owner;
		end
	end

	assign main_done = done_r && (served == owner_main);
	assign sub_done  = done_r && (served == owner_sub);
	// RAM data lands together with done
	assign rsp.rdata = ram_rdata;

	a_one_done: assert property (
		@(posedge clk_6m) disable iff (!arst_n)
		!(main_done && sub_done)
	);

endmodule

// File: verilog/shared_ram.sv
`timescale 1ns/100ps

module shared_ram import bus_pkg::*; #(
	parameter int ADDR_W = 13
) (
	input  logic       clk_6m,
	input  ram_cmd_t   cmd,
	output logic [7:0] rdata
);

	////////////////////////////////////////////////////////////
	// Work RAM array
	////////////////////////////////////////////////////////////

	localparam int unsigned WORDS = 2 ** ADDR_W;

	// 8K x 8 at the default width
	logic [7:0] mem [WORDS];

	logic [ADDR_W-1:0] idx;

	// Upper address bits are not decoded
	// Smaller RAM mirrors through the space
	assign idx = cmd.addr[ADDR_W-1:0];

	// Single port
	// Write or read per command, never both
	always_ff @(posedge clk_6m) begin
		if (cmd.en) begin
			if (cmd.we) begin
				mem[idx] <= cmd.wdata;
			end else begin
				// Registered read, valid the clock after the command
				rdata <= mem[idx];
			end
		end
	end

endmodule

// File: verilog/latch_regs.sv
`timescale 1ns/100ps

module latch_regs (
	input  logic       clk_6m,
	input  logic       arst_n,
	input  logic [1:0] lth_we,
	input  logic [7:0] lth_data,
	output logic [7:0] latch0,
	output logic [7:0] latch1,
	output logic       latch0_n,
	output logic       latch1_n
);

	////////////////////////////////////////////////////////////
	// Output latches
	////////////////////////////////////////////////////////////

	// Both selects set writes both latches
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			latch0 <= 8'h00;
			latch1 <= 8'h00;
		end else begin
			if (lth_we[0]) latch0 <= lth_data;
			if (lth_we[1]) latch1 <= lth_data;
		end
	end

	// Strobes low for the clock the new value appears
	always_ff @(posedge clk_6m or negedge arst_n) begin
		if (!arst_n) begin
			latch0_n <= 1'b1;
			latch1_n <= 1'b1;
		end else begin
			latch0_n <= !lth_we[0];
			latch1_n <= !lth_we[1];
		end
	end

	// Slots never repeat, so each strobe is a single clock
	a_stb0_single: assert property (
		@(posedge clk_6m) disable iff (!arst_n)
		!latch0_n |=> latch0_n
	);

	a_stb1_single: assert property (
		@(posedge clk_6m) disable iff (!arst_n)
		!latch1_n |=> latch1_n
	);

endmodule

// File: verilog/bus_subsystem.sv
`timescale 1ns/100ps

module bus_subsystem import bus_pkg::*; #(
	parameter int ADDR_W = 13
) (
	input  logic       clk_6m,
	input  logic       arst_n,
	// Main CPU
	input  logic       main_req,
	input  bus_req_t   main_cmd,
	output logic       main_ack,
	output bus_rsp_t   main_rsp,
	// Sub CPU
	input  logic       sub_req,
	input  bus_req_t   sub_cmd,
	output logic       sub_ack,
	output bus_rsp_t   sub_rsp,
	// Output latches
	output logic [7:0] latch0,
	output logic [7:0] latch1,
	output logic       latch0_n,
	output logic       latch1_n
);

	slot_owner_e owner;
	logic        acc;
	logic        main_pend, sub_pend;
	bus_req_t    main_held, sub_held;
	logic        main_done, sub_done;
	bus_rsp_t    done_rsp;
	ram_cmd_t    ram_cmd;
	logic [7:0]  ram_rdata;
	logic [1:0]  lth_we;
	logic [7:0]  lth_data;

	////////////////////////////////////////////////////////////
	// Slot timing and CPU ports
	////////////////////////////////////////////////////////////

	slot_timer slot_timer_i (.clk_6m, .arst_n, .owner, .acc);

	cpu_port main_port_i (
		.clk_6m, .arst_n,
		.req (main_req), .cmd (main_cmd), .ack (main_ack), .rsp (main_rsp),
		.pend (main_pend), .held (main_held), .done (main_done), .done_rsp
	);

	cpu_port sub_port_i (
		.clk_6m, .arst_n,
		.req (sub_req), .cmd (sub_cmd), .ack (sub_ack), .rsp (sub_rsp),
		.pend (sub_pend), .held (sub_held), .done (sub_done), .done_rsp
	);

	// Shared bus, RAM and latches
	bus_mux #(.ADDR_W (ADDR_W)) bus_mux_i (
		.clk_6m, .arst_n, .owner, .acc,
		.main_pend, .main_held, .sub_pend, .sub_held, .main_done, .sub_done,
		.rsp (done_rsp), .ram_cmd, .ram_rdata, .lth_we, .lth_data
	);

	shared_ram #(.ADDR_W (ADDR_W)) shared_ram_i (.clk_6m, .cmd (ram_cmd), .rdata (ram_rdata));

	latch_regs latch_regs_i (
		.clk_6m, .arst_n, .lth_we, .lth_data,
		.latch0, .latch1, .latch0_n, .latch1_n
	);

endmodule

// File: verif/tb_bus_subsystem.sv
`timescale 1ns/100ps

module tb_bus_subsystem import bus_pkg::*; ();

	localparam int          TIMEOUT  = 20;
	localparam int          N_RANDOM = 200;
	localparam logic [31:0] SEED     = 32'h442720c4;

	logic       clk_6m;
	logic       arst_n;
	logic       main_req, sub_req;
	bus_req_t   main_cmd, sub_cmd;
	logic       main_ack, sub_ack;
	bus_rsp_t   main_rsp, sub_rsp;
	logic [7:0] latch0, latch1;
	logic       latch0_n, latch1_n;

	bus_subsystem #(.ADDR_W (13)) dut_i (
		.clk_6m, .arst_n,
		.main_req, .main_cmd, .main_ack, .main_rsp,
		.sub_req, .sub_cmd, .sub_ack, .sub_rsp,
		.latch0, .latch1, .latch0_n, .latch1_n
	);

	// Reference state of the work RAM and the latches
	logic [7:0]  ram_model [int];
	logic [7:0]  latch0_model = 8'h00;
	logic [7:0]  latch1_model = 8'h00;
	logic [31:0] rng = SEED;
	int checks = 0;
	int errors = 0;
	int test_checks;
	int test_errors;
	int stb0_cnt = 0;
	int stb1_cnt = 0;

	initial begin
		clk_6m = 1'b0;
		forever #50 clk_6m = ~clk_6m;
	end

	// Low strobe clocks seen so far
	always @(posedge clk_6m) begin
		if (arst_n && !latch0_n) stb0_cnt <= stb0_cnt + 1;
		if (arst_n && !latch1_n) stb1_cnt <= stb1_cnt + 1;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic ack_of(input bit sub);
		return sub ? sub_ack : main_ack;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch %s: got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	// Polls ack once per clock, gives up after TIMEOUT clocks
	task automatic wait_ack(input bit sub, input logic level);
		int cnt;
		cnt = 0;
		while (ack_of(sub) !== level && cnt < TIMEOUT) begin
			cnt++;
			@(posedge clk_6m);
		end
		if (ack_of(sub) !== level) begin
			$display("Timeout: %s port ack never went %s",
				sub ? "sub" : "main", level ? "high" : "low");
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	// One full four phase transfer
	// CPU keeps req up for hold extra clocks after ack
	task automatic transfer(input bit sub, input bus_req_t c, input int hold,
			output logic [7:0] rdata);
		string port;
		port = sub ? "sub" : "main";
		@(posedge clk_6m);
		if (sub) begin
			sub_req <= 1'b1;
			sub_cmd <= c;
		end else begin
			main_req <= 1'b1;
			main_cmd <= c;
		end
		wait_ack(sub, 1'b1);
		// Read data valid together with ack
		rdata = sub ? sub_rsp.rdata : main_rsp.rdata;
		repeat (hold) begin
			@(posedge clk_6m);
			checks++;
			assert (ack_of(sub)) else begin
				$display("%s port dropped ack while req was still high", port);
				errors++;
			end
		end
		if (sub) begin
			sub_req <= 1'b0;
		end else begin
			main_req <= 1'b0;
		end
		@(posedge clk_6m);
		// Port has not seen req low yet
		checks++;
		assert (ack_of(sub)) else begin
			$display("%s port dropped ack before req fell", port);
			errors++;
		end
		wait_ack(sub, 1'b0);
	endtask

	task automatic ram_write(input bit sub, input logic [12:0] addr, input logic [7:0] data,
			input int hold);
		bus_req_t   c;
		logic [7:0] unused;
		c = '0;
		c.addr = addr;
		c.wdata = data;
		ram_model[addr] = data;
		transfer(sub, c, hold, unused);
	endtask

	task automatic ram_read(input bit sub, input logic [12:0] addr, input int hold);
		bus_req_t   c;
		logic [7:0] got;
		c = '0;
		c.addr = addr;
		c.rnw = 1'b1;
		transfer(sub, c, hold, got);
		check_val(sub ? "sub_rsp" : "main_rsp", got, ram_model[addr]);
	endtask

	// Latch write, RAM model untouched
	task automatic latch_write(input bit sub, input logic [12:0] addr, input logic [7:0] data,
			input logic [1:0] lth);
		bus_req_t   c;
		logic [7:0] unused;
		int         s0;
		int         s1;
		c = '0;
		c.addr = addr;
		c.wdata = data;
		c.lth = lth;
		s0 = stb0_cnt;
		s1 = stb1_cnt;
		if (lth[0]) latch0_model = data;
		if (lth[1]) latch1_model = data;
		transfer(sub, c, 0, unused);
		check_val("latch0", latch0, latch0_model);
		check_val("latch1", latch1, latch1_model);
		check_val("latch0_n low clocks", stb0_cnt - s0, lth[0]);
		check_val("latch1_n low clocks", stb1_cnt - s1, lth[1]);
	endtask

	task automatic begin_test();
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test(input string name);
		$display("test %s done: %0d checks, %0d errors", name,
			checks - test_checks, errors - test_errors);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic check_reset_state();
		begin_test();
		@(posedge clk_6m);
		check_val("main_ack", main_ack, 1'b0);
		check_val("sub_ack", sub_ack, 1'b0);
		check_val("latch0_n", latch0_n, 1'b1);
		check_val("latch1_n", latch1_n, 1'b1);
		check_val("latch0", latch0, 8'h00);
		check_val("latch1", latch1, 8'h00);
		end_test("reset_state");
	endtask

	// Main writes, sub reads back, then the other way round
	task automatic cross_port_rw();
		logic [12:0] a [4];
		begin_test();
		a = '{13'h0000, 13'h0155, 13'h0aaa, 13'h1fff};
		for (int i = 0; i < 4; i++) ram_write(0, a[i], 8'h11 * (i + 1), i % 3);
		for (int i = 0; i < 4; i++) ram_read(1, a[i], i % 2);
		for (int i = 0; i < 4; i++) ram_write(1, a[i] ^ 13'h0808, 8'hf0 - i, i % 2);
		for (int i = 0; i < 4; i++) ram_read(0, a[i] ^ 13'h0808, i % 3);
		end_test("cross_port_rw");
	endtask

	// Both req lines rise on the same edge
	task automatic simultaneous_req();
		begin_test();
		fork
			ram_write(0, 13'h0100, 8'ha5, 0);
			ram_write(1, 13'h1100, 8'h5a, 1);
		join
		fork
			ram_read(0, 13'h1100, 2);
			ram_read(1, 13'h0100, 0);
		join
		end_test("simultaneous_req");
	endtask

	task automatic latch_writes();
		begin_test();
		ram_write(0, 13'h0042, 8'h5a, 0);
		latch_write(0, 13'h0042, 8'hc3, 2'b01);
		latch_write(1, 13'h0042, 8'h3c, 2'b10);
		latch_write(0, 13'h0042, 8'h96, 2'b11);
		// RAM word behind the latch address must survive
		ram_read(1, 13'h0042, 0);
		end_test("latch_writes");
	endtask

	task automatic random_ops();
		logic [12:0] addr;
		begin_test();
		for (int i = 0; i < N_RANDOM; i++) begin
			rng = xorshift(rng);
			addr = {rng[28:27], 5'h00, rng[13:8]};
			// Reads go only to words already written
			if (rng[1] && ram_model.exists(addr)) begin
				ram_read(rng[0], addr, rng[3:2]);
			end else begin
				ram_write(rng[0], addr, rng[23:16], rng[3:2]);
			end
		end
		end_test("random_ops");
	endtask

	initial begin
		arst_n = 1'b0;
		main_req = 1'b0;
		sub_req = 1'b0;
		main_cmd = '0;
		sub_cmd = '0;
		repeat (10) @(posedge clk_6m);
		arst_n <= 1'b1;
		check_reset_state();
		cross_port_rw();
		simultaneous_req();
		latch_writes();
		random_ops();
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
verilog/bus_pkg.sv
verilog/slot_timer.sv
verilog/cpu_port.sv
verilog/bus_mux.sv
verilog/shared_ram.sv
verilog/latch_regs.sv
verilog/bus_subsystem.sv
verif/tb_bus_subsystem.sv

// File: Bender.yml
package:
  name: bus_subsystem

sources:
  - verilog/bus_pkg.sv
  - verilog/slot_timer.sv
  - verilog/cpu_port.sv
  - verilog/bus_mux.sv
  - verilog/shared_ram.sv
  - verilog/latch_regs.sv
  - verilog/bus_subsystem.sv
  - target: simulation
    files:
      - verif/tb_bus_subsystem.sv
